/* elevator_macros.svh */
`ifndef ELEVATOR_MACROS_SVH
`define ELEVATOR_MACROS_SVH

// Building size
`define FLOORS 11

// Floor number width, floor 1 is coded 0 and floor 11 is coded 10
`define FLOOR_W 4

// Motion state code width from the elevator FSM
`define STATE_W 6

// Request stack sizing
`define STACK_DEPTH 11
`define PTR_W 4

// FSM code of the emergency state
`define EMERGENCY_STATE 31

`endif

/* elevator_pkg.sv */
`include "elevator_macros.svh"

package elevator_pkg;

    // One floor number
    typedef logic [`FLOOR_W-1:0] floor_t;

    // One bit per floor, bit n is the floor coded n
    typedef logic [`FLOORS-1:0] floor_mask_t;

    // Motion FSM state code
    // 0 to 10 stopped at that floor, 11 to 30 travelling, 31 emergency
    typedef logic [`STATE_W-1:0] elevator_state_t;

    // True for the stopped codes only
    function automatic logic is_stop_state(input elevator_state_t state);
        return (state < `FLOORS);
    endfunction

endpackage

/* request_capture.sv */
`include "elevator_macros.svh"

module request_capture (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      emergency_button,
    input  logic                      power_switch,
    input  elevator_pkg::floor_t      current_floor,
    input  logic                      full,
    input  logic                      served,
    input  elevator_pkg::floor_t      served_floor,
    output logic                      push,
    output elevator_pkg::floor_t      push_floor,
    output logic                      flush,
    output elevator_pkg::floor_mask_t call_button_lights,
    output elevator_pkg::floor_mask_t panel_button_lights
);

    ////////////////////////////////////////////////////////////
    // Eligibility and selection
    ////////////////////////////////////////////////////////////

    elevator_pkg::floor_mask_t lit;
    elevator_pkg::floor_mask_t here_mask;
    elevator_pkg::floor_mask_t call_elig;
    elevator_pkg::floor_mask_t panel_elig;
    elevator_pkg::floor_mask_t push_mask;
    elevator_pkg::floor_mask_t served_mask;
    elevator_pkg::floor_t      pick_floor;
    logic                      pick_valid;
    logic                      pick_panel;
    logic                      accept_ok;

    assign flush = emergency_button || !power_switch;

    // No new requests during flush, retire or a full stack
    assign accept_ok = !flush && !served && !full;

    assign lit        = call_button_lights | panel_button_lights;
    assign here_mask  = elevator_pkg::floor_mask_t'(1) << current_floor;
    assign call_elig  = floor_call_buttons & ~lit & ~here_mask;
    assign panel_elig = panel_buttons & ~lit & ~here_mask;

    // Lowest floor wins, panel scan last so it overrides the calls
    always_comb begin
        pick_floor = '0;
        pick_valid = 1'b0;
        pick_panel = 1'b0;
        for (int i = `FLOORS - 1; i >= 0; i--) begin
            if (call_elig[i]) begin
                pick_floor = elevator_pkg::floor_t'(i);
                pick_valid = 1'b1;
            end
        end
        for (int i = `FLOORS - 1; i >= 0; i--) begin
            if (panel_elig[i]) begin
                pick_floor = elevator_pkg::floor_t'(i);
                pick_valid = 1'b1;
                pick_panel = 1'b1;
            end
        end
    end

    assign push       = accept_ok && pick_valid;
    assign push_floor = pick_floor;

    ////////////////////////////////////////////////////////////
    // Button lamps
    ////////////////////////////////////////////////////////////

    assign push_mask   = elevator_pkg::floor_mask_t'(1) << pick_floor;
    assign served_mask = elevator_pkg::floor_mask_t'(1) << served_floor;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else if (flush) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else if (served) begin
            // Arrival clears both lamps of that floor
            call_button_lights  <= call_button_lights & ~served_mask;
            panel_button_lights <= panel_button_lights & ~served_mask;
        end else if (push) begin
            if (pick_panel)
                panel_button_lights <= panel_button_lights | push_mask;
            else
                call_button_lights <= call_button_lights | push_mask;
        end
    end

    // A retired floor must still have one of its lamps lit
    served_was_lit: assert property (@(posedge clock) disable iff (!reset_n)
        served |-> lit[served_floor]);

endmodule

/* floor_stack.sv */
`include "elevator_macros.svh"

module floor_stack (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 push,
    input  elevator_pkg::floor_t push_floor,
    input  logic                 pop,
    input  logic                 flush,
    output elevator_pkg::floor_t top_floor,
    output logic                 empty,
    output logic                 full
);

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    elevator_pkg::floor_t entries [`STACK_DEPTH];
    logic [`PTR_W-1:0]    count;
    logic [`PTR_W-1:0]    top_idx;

    assign empty = (count == '0);
    assign full  = (count == `PTR_W'(`STACK_DEPTH));

    // Slot below the count holds the newest floor
    assign top_idx   = empty ? '0 : count - 1'b1;
    assign top_floor = entries[top_idx];

    // Next free slot is written on push
    always_ff @(posedge clock) begin
        if (push && !flush && !full) begin
            entries[count] <= push_floor;
        end
    end

    ////////////////////////////////////////////////////////////
    // Fill count
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else if (push && !full) begin
            count <= count + 1'b1;
        end else if (pop && !empty) begin
            count <= count - 1'b1;
        end
    end

    // Capture and dispatch must respect the stack bounds
    no_push_full: assert property (@(posedge clock) disable iff (!reset_n)
        push |-> !full);

    no_pop_empty: assert property (@(posedge clock) disable iff (!reset_n)
        pop |-> !empty);

endmodule

/* dispatcher.sv */
`include "elevator_macros.svh"

module dispatcher (
    input  logic                          clock,
    input  logic                          reset_n,
    input  elevator_pkg::floor_t          top_floor,
    input  logic                          empty,
    input  elevator_pkg::floor_t          current_floor,
    input  elevator_pkg::elevator_state_t elevator_state,
    input  logic                          emergency_button,
    input  logic                          power_switch,
    input  logic                          door_open_button,
    input  logic                          door_close_button,
    output logic                          pop,
    output logic                          served,
    output elevator_pkg::floor_t          served_floor,
    output elevator_pkg::floor_t          floor_selector,
    output logic                          direction,
    output logic                          activate,
    output logic                          door_open_allowed,
    output logic                          door_close_allowed
);

    ////////////////////////////////////////////////////////////
    // Target offer
    ////////////////////////////////////////////////////////////

    logic stopped;
    logic powered_stop;
    logic offering;
    logic at_target;

    assign stopped      = elevator_pkg::is_stop_state(elevator_state);
    assign powered_stop = stopped && power_switch;

    // Stopped, powered, no emergency and something waiting
    assign offering  = powered_stop && !emergency_button && !empty;
    assign at_target = (top_floor == current_floor);

    // Idle selector rests on the current floor
    assign floor_selector = offering ? top_floor : current_floor;
    assign direction      = offering && (top_floor > current_floor);
    assign activate       = offering && !at_target;

    ////////////////////////////////////////////////////////////
    // Retire on arrival
    ////////////////////////////////////////////////////////////

    // Car already sits at the stack top so that entry is done
    assign served       = offering && at_target;
    assign pop          = served;
    assign served_floor = top_floor;

    // Door requests only reach the FSM while parked with power
    assign door_open_allowed  = powered_stop && door_open_button;
    assign door_close_allowed = powered_stop && door_close_button;

    // A stop code names the floor the car stands at
    stop_code_matches_floor: assert property (@(posedge clock) disable iff (!reset_n)
        stopped |-> (elevator_state == elevator_pkg::elevator_state_t'(current_floor)));

endmodule

/* floor_logic_top.sv */
`include "elevator_macros.svh"

module floor_logic_top (
    input  logic                          clock,
    input  logic                          reset_n,
    input  elevator_pkg::floor_mask_t     floor_call_buttons,
    input  elevator_pkg::floor_mask_t     panel_buttons,
    input  logic                          door_open_button,
    input  logic                          door_close_button,
    input  logic                          emergency_button,
    input  logic                          power_switch,
    input  elevator_pkg::floor_t          current_floor,
    input  elevator_pkg::elevator_state_t elevator_state,
    output elevator_pkg::floor_t          floor_selector,
    output logic                          direction,
    output logic                          activate,
    output logic                          door_open_allowed,
    output logic                          door_close_allowed,
    output elevator_pkg::floor_mask_t     call_button_lights,
    output elevator_pkg::floor_mask_t     panel_button_lights
);

    // Capture to stack
    logic                 push;
    elevator_pkg::floor_t push_floor;
    logic                 flush;

    // Stack status
    elevator_pkg::floor_t top_floor;
    logic                 empty;
    logic                 full;

    // Dispatcher feedback
    logic                 pop;
    logic                 served;
    elevator_pkg::floor_t served_floor;

    request_capture u_capture (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .emergency_button    (emergency_button),
        .power_switch        (power_switch),
        .current_floor       (current_floor),
        .full                (full),
        .served              (served),
        .served_floor        (served_floor),
        .push                (push),
        .push_floor          (push_floor),
        .flush               (flush),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    floor_stack u_stack (
        .clock      (clock),
        .reset_n    (reset_n),
        .push       (push),
        .push_floor (push_floor),
        .pop        (pop),
        .flush      (flush),
        .top_floor  (top_floor),
        .empty      (empty),
        .full       (full)
    );

    dispatcher u_dispatch (
        .clock              (clock),
        .reset_n            (reset_n),
        .top_floor          (top_floor),
        .empty              (empty),
        .current_floor      (current_floor),
        .elevator_state     (elevator_state),
        .emergency_button   (emergency_button),
        .power_switch       (power_switch),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .pop                (pop),
        .served             (served),
        .served_floor       (served_floor),
        .floor_selector     (floor_selector),
        .direction          (direction),
        .activate           (activate),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

/* tb_floor_logic.sv */
`include "elevator_macros.svh"

module tb_floor_logic;

    localparam int PERIOD = 40;
    // Cycles per test (reset, single, LIFO, reject, flush, doors) plus margin
    localparam int BUDGET = 10 + 8 + 12 + 14 + 14 + 8 + 40;

    logic                          clock = 1'b0;
    logic                          reset_n;
    elevator_pkg::floor_mask_t     floor_call_buttons;
    elevator_pkg::floor_mask_t     panel_buttons;
    logic                          door_open_button;
    logic                          door_close_button;
    logic                          emergency_button;
    logic                          power_switch;
    elevator_pkg::floor_t          current_floor;
    elevator_pkg::elevator_state_t elevator_state;
    elevator_pkg::floor_t          floor_selector;
    logic                          direction;
    logic                          activate;
    logic                          door_open_allowed;
    logic                          door_close_allowed;
    elevator_pkg::floor_mask_t     call_button_lights;
    elevator_pkg::floor_mask_t     panel_button_lights;

    integer seed = 32'h501e8297;
    int     errors = 0;

    floor_logic_top dut (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .door_open_button    (door_open_button),
        .door_close_button   (door_close_button),
        .emergency_button    (emergency_button),
        .power_switch        (power_switch),
        .current_floor       (current_floor),
        .elevator_state      (elevator_state),
        .floor_selector      (floor_selector),
        .direction           (direction),
        .activate            (activate),
        .door_open_allowed   (door_open_allowed),
        .door_close_allowed  (door_close_allowed),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    always #(PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic elevator_pkg::floor_t rand_floor();
        return elevator_pkg::floor_t'($unsigned($random(seed)) % `FLOORS);
    endfunction

    function automatic elevator_pkg::floor_t pick_other(input elevator_pkg::floor_t a,
                                                        input elevator_pkg::floor_t b);
        elevator_pkg::floor_t f;
        f = rand_floor();
        while (f == a || f == b)
            f = rand_floor();
        return f;
    endfunction

    // Lamp or button bit of one floor
    function automatic elevator_pkg::floor_mask_t floor_bit(input elevator_pkg::floor_t f);
        return elevator_pkg::floor_mask_t'(1) << f;
    endfunction

    // Inputs change 5 units after the rising edge
    task automatic tick();
        @(posedge clock);
        #5;
    endtask

    // Car stopped at floor f, stop codes equal the floor code
    task automatic park(input elevator_pkg::floor_t f);
        current_floor  = f;
        elevator_state = elevator_pkg::elevator_state_t'(f);
    endtask

    // One cycle of button presses, returns one cycle later
    task automatic press(input elevator_pkg::floor_mask_t panel,
                         input elevator_pkg::floor_mask_t call);
        panel_buttons      = panel;
        floor_call_buttons = call;
        tick();
        panel_buttons      = '0;
        floor_call_buttons = '0;
        #1;
    endtask

    task automatic check_floor(input string name, input elevator_pkg::floor_t expected,
                               input elevator_pkg::floor_t actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_mask(input string name, input elevator_pkg::floor_mask_t expected,
                              input elevator_pkg::floor_mask_t actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] t=%0t %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] t=%0t %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        #1;
        check_mask("call_button_lights", '0, call_button_lights);
        check_mask("panel_button_lights", '0, panel_button_lights);
        check_bit("activate", 1'b0, activate);
        check_floor("floor_selector", current_floor, floor_selector);
    endtask

    task automatic test_single();
        elevator_pkg::floor_t start;
        elevator_pkg::floor_t target;
        start  = current_floor;
        target = pick_other(start, start);
        tick();
        press(floor_bit(target), '0);
        check_mask("panel_button_lights", floor_bit(target), panel_button_lights);
        check_floor("floor_selector", target, floor_selector);
        check_bit("direction", target > start, direction);
        check_bit("activate", 1'b1, activate);
        // Arrival retires the request
        tick();
        park(target);
        #1;
        check_bit("activate", 1'b0, activate);
        tick();
        #1;
        check_mask("panel_button_lights", '0, panel_button_lights);
        check_floor("floor_selector", target, floor_selector);
        check_bit("activate", 1'b0, activate);
    endtask

    task automatic test_lifo();
        elevator_pkg::floor_t here;
        elevator_pkg::floor_t a;
        elevator_pkg::floor_t b;
        here = current_floor;
        a    = pick_other(here, here);
        b    = pick_other(here, a);
        tick();
        press('0, floor_bit(a));
        check_mask("call_button_lights", floor_bit(a), call_button_lights);
        check_floor("floor_selector", a, floor_selector);
        tick();
        press(floor_bit(b), '0);
        check_mask("panel_button_lights", floor_bit(b), panel_button_lights);
        // Newest entry on top
        check_floor("floor_selector", b, floor_selector);
        check_bit("direction", b > here, direction);
        tick();
        park(b);
        #1;
        check_bit("activate", 1'b0, activate);
        tick();
        #1;
        check_mask("panel_button_lights", '0, panel_button_lights);
        check_mask("call_button_lights", floor_bit(a), call_button_lights);
        check_floor("floor_selector", a, floor_selector);
        check_bit("direction", a > b, direction);
        check_bit("activate", 1'b1, activate);
        tick();
        park(a);
        tick();
        #1;
        check_mask("call_button_lights", '0, call_button_lights);
        check_floor("floor_selector", a, floor_selector);
        check_bit("activate", 1'b0, activate);
    endtask

    task automatic test_reject();
        elevator_pkg::floor_t here;
        elevator_pkg::floor_t a;
        elevator_pkg::floor_t b;
        here = current_floor;
        a    = pick_other(here, here);
        b    = pick_other(here, a);
        tick();
        press(floor_bit(here), '0);
        check_mask("panel_button_lights", '0, panel_button_lights);
        check_floor("floor_selector", here, floor_selector);
        check_bit("activate", 1'b0, activate);
        tick();
        press(floor_bit(a), '0);
        check_mask("panel_button_lights", floor_bit(a), panel_button_lights);
        // A call for a floor already lit on the panel is ignored
        tick();
        press('0, floor_bit(a));
        check_mask("panel_button_lights", floor_bit(a), panel_button_lights);
        check_mask("call_button_lights", '0, call_button_lights);
        check_floor("floor_selector", a, floor_selector);
        // Travelling codes: nothing is offered
        tick();
        elevator_state = elevator_pkg::elevator_state_t'(`FLOORS + ($unsigned($random(seed)) % 20));
        #1;
        check_floor("floor_selector", here, floor_selector);
        check_bit("activate", 1'b0, activate);
        tick();
        press(floor_bit(b), '0);
        check_mask("panel_button_lights", floor_bit(a) | floor_bit(b), panel_button_lights);
        check_floor("floor_selector", here, floor_selector);
        check_bit("activate", 1'b0, activate);
        tick();
        park(here);
        #1;
        check_floor("floor_selector", b, floor_selector);
    endtask

    task automatic test_flush();
        elevator_pkg::floor_t x;
        x = pick_other(current_floor, current_floor);
        tick();
        press('0, floor_bit(x));
        check_bit("lamps lit before emergency", 1'b1,
                  |(call_button_lights | panel_button_lights));
        tick();
        emergency_button = 1'b1;
        tick();
        emergency_button = 1'b0;
        #1;
        check_mask("call_button_lights", '0, call_button_lights);
        check_mask("panel_button_lights", '0, panel_button_lights);
        check_bit("activate", 1'b0, activate);
        check_floor("floor_selector", current_floor, floor_selector);
        tick();
        press(floor_bit(x), '0);
        check_mask("panel_button_lights", floor_bit(x), panel_button_lights);
        tick();
        power_switch = 1'b0;
        tick();
        power_switch = 1'b1;
        #1;
        check_mask("panel_button_lights", '0, panel_button_lights);
        check_bit("activate", 1'b0, activate);
        check_floor("floor_selector", current_floor, floor_selector);
    endtask

    task automatic test_doors();
        elevator_pkg::floor_t here;
        here = current_floor;
        tick();
        door_open_button  = 1'b1;
        door_close_button = 1'b0;
        #1;
        check_bit("door_open_allowed", 1'b1, door_open_allowed);
        check_bit("door_close_allowed", 1'b0, door_close_allowed);
        tick();
        door_open_button  = 1'b0;
        door_close_button = 1'b1;
        #1;
        check_bit("door_open_allowed", 1'b0, door_open_allowed);
        check_bit("door_close_allowed", 1'b1, door_close_allowed);
        tick();
        door_open_button = 1'b1;
        elevator_state   = elevator_pkg::elevator_state_t'(`FLOORS + 5);
        #1;
        check_bit("door_open_allowed", 1'b0, door_open_allowed);
        check_bit("door_close_allowed", 1'b0, door_close_allowed);
        tick();
        elevator_state = elevator_pkg::elevator_state_t'(`EMERGENCY_STATE);
        #1;
        check_bit("door_open_allowed", 1'b0, door_open_allowed);
        check_bit("door_close_allowed", 1'b0, door_close_allowed);
        tick();
        park(here);
        power_switch = 1'b0;
        #1;
        check_bit("door_open_allowed", 1'b0, door_open_allowed);
        check_bit("door_close_allowed", 1'b0, door_close_allowed);
        tick();
        power_switch      = 1'b1;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Run
    ////////////////////////////////////////////////////////////

    initial begin
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_button   = 1'b0;
        door_close_button  = 1'b0;
        emergency_button   = 1'b0;
        power_switch       = 1'b1;
        park(rand_floor());
        repeat (8) @(posedge clock);
        #5;
        reset_n = 1'b1;
        test_reset();
        test_single();
        test_lifo();
        test_reject();
        test_flush();
        test_doors();
        $display("Checks done, error count %0d", errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Watchdog
    initial begin
        #(BUDGET * PERIOD);
        $display("Watchdog expired, the tests did not finish within %0d cycles", BUDGET);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+.
elevator_pkg.sv
request_capture.sv
floor_stack.sv
dispatcher.sv
floor_logic_top.sv
tb_floor_logic.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failure
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_floor_logic \
    -f src.f -o sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
# A simulator error exit counts as a failed run
./obj_dir/sim > sim.log 2>&1 || echo "SOME TESTS FAILED" >> sim.log
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Result: FAIL"; exit 1; } \
    || { echo "Result: PASS"; exit 0; }
